/* Bender.yml */
package:
  name: fib_top

export_include_dirs:
  - include

sources:
  - src/fib_pkg.sv
  - src/fib_if.sv
  - src/fib_decode.sv
  - src/fib_lookup_fsm.sv
  - src/fib_table.sv
  - src/fib_result.sv
  - src/fib_top.sv
  - target: simulation
    files:
      - verification/fib_tb_clock.sv
      - verification/fib_checker.sv
      - verification/tb_fib_top.sv

/* fib_top.f */
+incdir+include
src/fib_pkg.sv
src/fib_if.sv
src/fib_decode.sv
src/fib_lookup_fsm.sv
src/fib_table.sv
src/fib_result.sv
src/fib_top.sv
verification/fib_tb_clock.sv
verification/fib_checker.sv
verification/tb_fib_top.sv

/* include/fib_cfg.svh */
`ifndef FIB_CFG_SVH
`define FIB_CFG_SVH

// forwarding table geometry
`define FIB_ENTRIES 16
`define FIB_ASZ     4

// switch ports
`define NUM_PORTS   4
`define PORT_SZ     2

// entry age, written fresh on every learn
`define FIB_MAX_AGE 3
`define FIB_AGE_SZ  2

// buffer manager side
`define LL_PG_ASZ   8
`define LL_REFSZ    3

`endif

/* src/fib_decode.sv */
`include "fib_cfg.svh"

module fib_decode
(
  input  logic               clk,
  input  logic               reset,
  input  logic               lpp_srdy,
  input  fib_pkg::par_desc_t lpp_data,
  output logic               lpp_drdy,
  fib_req_if.source          req
);
  import fib_pkg::*;

  localparam logic [`FIB_ASZ:0] wake_end = `FIB_ENTRIES;

  par_desc_t         desc_q;
  logic              full_q;
  logic [`FIB_ASZ:0] wake_ctr;  // tracks the table clear after reset
  logic              armed;

  assign armed    = (wake_ctr == wake_end);
  assign lpp_drdy = armed & ~full_q;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      full_q   <= 1'b0;
      wake_ctr <= '0;
    end
    else
    begin
      if (!armed)
        wake_ctr <= wake_ctr + 1'b1;
      if (lpp_srdy && lpp_drdy)
        full_q <= 1'b1;
      else if (req.srdy && req.drdy)
        full_q <= 1'b0;  // lookup has learned the SA
    end
  end

  always_ff @(posedge clk)
  begin
    if (lpp_srdy && lpp_drdy)
      desc_q <= lpp_data;
  end

  assign req.srdy     = full_q;
  assign req.desc     = desc_q;
  assign req.is_mcast = desc_q.mac_da[40];  // low bit of first octet
  assign req.src_mask = `NUM_PORTS'(1) << desc_q.src_port;

endmodule

/* src/fib_if.sv */
`include "fib_cfg.svh"

// descriptor from decode to lookup
interface fib_req_if;
  import fib_pkg::*;

  logic                  srdy;
  logic                  drdy;
  par_desc_t             desc;
  logic                  is_mcast;  // group bit of the DA
  logic [`NUM_PORTS-1:0] src_mask;  // one-hot source port

  modport source (output srdy, desc, is_mcast, src_mask, input drdy);
  modport sink   (input srdy, desc, is_mcast, src_mask, output drdy);
endinterface

// lookup FSM to table memory
interface fib_mem_if;
  import fib_pkg::*;

  logic                rd_en;
  logic                wr_en;
  logic [`FIB_ASZ-1:0] addr;
  fib_entry_t          wdata;
  fib_entry_t          rdata;  // valid the cycle after rd_en

  modport master (output rd_en, wr_en, addr, wdata, input rdata);
  modport slave  (input rd_en, wr_en, addr, wdata, output rdata);
endinterface

// forwarding decision from lookup to result buffers
interface fib_res_if;
  logic                  srdy;
  logic                  drdy;
  logic [`LL_PG_ASZ-1:0] start_pg;
  logic [`NUM_PORTS-1:0] dst_vld;

  modport source (output srdy, start_pg, dst_vld, input drdy);
  modport sink   (input srdy, start_pg, dst_vld, output drdy);
endinterface

/* src/fib_lookup_fsm.sv */
`include "fib_cfg.svh"

module fib_lookup_fsm
(
  input  logic      clk,
  input  logic      reset,
  fib_req_if.sink   req,
  fib_mem_if.master mem,
  fib_res_if.source res
);
  import fib_pkg::*;

  lookup_state_t         state;
  lookup_state_t         nxt_state;
  logic [`FIB_ASZ-1:0]   init_ctr;
  logic [47:0]           hash_in;
  logic [`FIB_ASZ-1:0]   hash_out;
  logic                  hit;
  logic [`NUM_PORTS-1:0] flood_mask;
  logic [`NUM_PORTS-1:0] learned_mask;

  // xor-fold the MAC into table address sized nibbles
  function automatic logic [`FIB_ASZ-1:0] mac_hash(input logic [47:0] mac);
    logic [`FIB_ASZ-1:0] h;
    h = '0;
    for (int i = 0; i < 48 / `FIB_ASZ; i++)
      h = h ^ mac[i*`FIB_ASZ +: `FIB_ASZ];
    return h;
  endfunction

  // SA while learning, DA otherwise
  assign hash_in  = (state == s_sa_learn) ? req.desc.mac_sa : req.desc.mac_da;
  assign hash_out = mac_hash(hash_in);

  // table clear walks the init counter, lookups use the hash
  assign mem.addr = (state == s_init) ? init_ctr : hash_out;

  assign mem.rd_en = (state == s_idle) && req.srdy && !req.is_mcast;
  assign mem.wr_en = (state == s_init) || (state == s_sa_learn);

  always_comb
  begin
    if (state == s_init)
      mem.wdata = '0;
    else
      mem.wdata = '{mac:  req.desc.mac_sa,
                    age:  `FIB_AGE_SZ'(`FIB_MAX_AGE),
                    port: req.desc.src_port};
  end

  // only the DA lookup state has table data to judge
  assign hit = (state == s_da_lookup) &&
               (mem.rdata.age != '0) &&
               (mem.rdata.mac == req.desc.mac_da);

  assign flood_mask   = ~req.src_mask;
  assign learned_mask = (`NUM_PORTS'(1) << mem.rdata.port) & ~req.src_mask;

  assign res.dst_vld  = hit ? learned_mask : flood_mask;
  assign res.start_pg = req.desc.start_pg;
  assign res.srdy     = ((state == s_idle) && req.srdy && req.is_mcast) ||
                        (state == s_da_lookup) ||
                        (state == s_wait_result);

  // descriptor is done once its source is written back
  assign req.drdy = (state == s_sa_learn);

  always_comb
  begin
    nxt_state = state;
    case (state)
      s_init:
      begin
        if (init_ctr == `FIB_ASZ'(`FIB_ENTRIES - 1))
          nxt_state = s_idle;
      end
      s_idle:
      begin
        if (req.srdy)
        begin
          if (!req.is_mcast)
            nxt_state = s_da_lookup;
          else if (res.drdy)
            nxt_state = s_sa_learn;  // flooded straight away
          else
            nxt_state = s_wait_result;
        end
      end
      s_da_lookup:
      begin
        if (res.drdy)
          nxt_state = s_sa_learn;
      end
      s_wait_result:
      begin
        if (res.drdy)
          nxt_state = s_sa_learn;
      end
      s_sa_learn:
        nxt_state = s_idle;
      default:
        nxt_state = s_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= s_init;
      init_ctr <= '0;
    end
    else
    begin
      state <= nxt_state;
      if (state == s_init)
        init_ctr <= init_ctr + 1'b1;
    end
  end

endmodule

/* src/fib_pkg.sv */
`include "fib_cfg.svh"

package fib_pkg;

  // parsed packet descriptor from the parser
  typedef struct packed {
    logic [47:0]            mac_da;
    logic [47:0]            mac_sa;
    logic [`PORT_SZ-1:0]    src_port;
    logic [`LL_PG_ASZ-1:0]  start_pg;
  } par_desc_t;

  // one forwarding table slot, age of zero means empty
  typedef struct packed {
    logic [47:0]            mac;
    logic [`FIB_AGE_SZ-1:0] age;
    logic [`PORT_SZ-1:0]    port;
  } fib_entry_t;

  typedef enum logic [2:0] {
    s_init,
    s_idle,
    s_da_lookup,
    s_sa_learn,
    s_wait_result
  } lookup_state_t;

endpackage

/* src/fib_result.sv */
`include "fib_cfg.svh"

module fib_result
(
  input  logic                  clk,
  input  logic                  reset,
  fib_res_if.sink               res,
  output logic                  lout_srdy,
  output logic [`LL_PG_ASZ-1:0] lout_start,
  output logic [`NUM_PORTS-1:0] lout_dst_vld,
  input  logic                  lout_drdy,
  output logic                  refup_srdy,
  output logic [`LL_PG_ASZ-1:0] refup_page,
  output logic [`LL_REFSZ-1:0]  refup_count,
  input  logic                  refup_drdy
);

  logic load;

  function automatic logic [`LL_REFSZ-1:0] count_bits(input logic [`NUM_PORTS-1:0] dst);
    logic [`LL_REFSZ-1:0] cnt;
    cnt = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
      cnt = cnt + `LL_REFSZ'(dst[i]);
    return cnt;
  endfunction

  // take a new item only with both buffers drained
  assign res.drdy = ~lout_srdy & ~refup_srdy;
  assign load     = res.srdy & res.drdy;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      lout_srdy  <= 1'b0;
      refup_srdy <= 1'b0;
    end
    else
    begin
      if (load)
        lout_srdy <= 1'b1;
      else if (lout_drdy)
        lout_srdy <= 1'b0;
      if (load)
        refup_srdy <= 1'b1;
      else if (refup_drdy)
        refup_srdy <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      lout_start   <= res.start_pg;
      lout_dst_vld <= res.dst_vld;
      refup_page   <= res.start_pg;
      refup_count  <= count_bits(res.dst_vld);  // one reference per port
    end
  end

endmodule

/* src/fib_table.sv */
`include "fib_cfg.svh"

module fib_table
(
  input logic      clk,
  fib_mem_if.slave mem
);
  import fib_pkg::*;

  fib_entry_t entries [`FIB_ENTRIES];

  // contents cleared by the lookup FSM after reset
  always_ff @(posedge clk)
  begin
    if (mem.wr_en)
      entries[mem.addr] <= mem.wdata;
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge clk)
  begin
    if (mem.rd_en)
      mem.rdata <= entries[mem.addr];
  end

endmodule

/* src/fib_top.sv */
`include "fib_cfg.svh"

module fib_top
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  lpp_srdy,
  input  fib_pkg::par_desc_t    lpp_data,
  output logic                  lpp_drdy,
  output logic                  lout_srdy,
  output logic [`LL_PG_ASZ-1:0] lout_start,
  output logic [`NUM_PORTS-1:0] lout_dst_vld,
  input  logic                  lout_drdy,
  output logic                  refup_srdy,
  output logic [`LL_PG_ASZ-1:0] refup_page,
  output logic [`LL_REFSZ-1:0]  refup_count,
  input  logic                  refup_drdy
);

  fib_req_if req_if ();
  fib_mem_if mem_if ();
  fib_res_if res_if ();

  fib_decode decode (
    .clk      (clk),
    .reset    (reset),
    .lpp_srdy (lpp_srdy),
    .lpp_data (lpp_data),
    .lpp_drdy (lpp_drdy),
    .req      (req_if.source)
  );

  fib_lookup_fsm lookup (
    .clk   (clk),
    .reset (reset),
    .req   (req_if.sink),
    .mem   (mem_if.master),
    .res   (res_if.source)
  );

  fib_table table_mem (
    .clk (clk),
    .mem (mem_if.slave)
  );

  fib_result result (
    .clk          (clk),
    .reset        (reset),
    .res          (res_if.sink),
    .lout_srdy    (lout_srdy),
    .lout_start   (lout_start),
    .lout_dst_vld (lout_dst_vld),
    .lout_drdy    (lout_drdy),
    .refup_srdy   (refup_srdy),
    .refup_page   (refup_page),
    .refup_count  (refup_count),
    .refup_drdy   (refup_drdy)
  );

endmodule

/* verification/fib_checker.sv */
`include "fib_cfg.svh"

module fib_checker
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  lpp_srdy,
  input  fib_pkg::par_desc_t    lpp_data,
  input  logic                  lpp_drdy,
  input  logic                  lout_srdy,
  input  logic [`LL_PG_ASZ-1:0] lout_start,
  input  logic [`NUM_PORTS-1:0] lout_dst_vld,
  input  logic                  lout_drdy,
  input  logic                  refup_srdy,
  input  logic [`LL_PG_ASZ-1:0] refup_page,
  input  logic [`LL_REFSZ-1:0]  refup_count,
  input  logic                  refup_drdy,
  input  logic                  test_end,
  input  int                    test_num,
  output int                    pending,
  output int                    errors,
  output int                    failed_tests
);
  import fib_pkg::*;

  // reference table
  logic [47:0]          mdl_mac [`FIB_ENTRIES];
  int                   mdl_age [`FIB_ENTRIES];
  int                   mdl_port [`FIB_ENTRIES];
  logic [`LL_PG_ASZ-1:0] exp_pg[$];
  logic [`NUM_PORTS-1:0] exp_mask[$];
  logic [`LL_PG_ASZ-1:0] exp_ref_pg[$];
  int                   exp_cnt[$];
  int                   t_pkts;
  int                   t_errs;
  int                   init_cycles;  // cycles of table clear seen so far

  // xor of all twelve nibbles of the MAC
  function automatic logic [`FIB_ASZ-1:0] mac_slot(input logic [47:0] mac);
    logic [`FIB_ASZ-1:0] s;
    s = '0;
    for (int i = 0; i < 48; i += `FIB_ASZ)
      s ^= mac[i +: `FIB_ASZ];
    return s;
  endfunction

  task automatic predict(input par_desc_t d);
    logic [`FIB_ASZ-1:0]   da_slot;
    logic [`FIB_ASZ-1:0]   sa_slot;
    logic [`NUM_PORTS-1:0] mask;
    da_slot = mac_slot(d.mac_da);
    sa_slot = mac_slot(d.mac_sa);
    if (!d.mac_da[40] && mdl_age[da_slot] != 0 && mdl_mac[da_slot] == d.mac_da)
      mask = `NUM_PORTS'(1) << mdl_port[da_slot];
    else
      mask = '1;  // flood
    mask &= ~(`NUM_PORTS'(1) << d.src_port);
    exp_pg.push_back(d.start_pg);
    exp_mask.push_back(mask);
    exp_ref_pg.push_back(d.start_pg);
    exp_cnt.push_back($countones(mask));
    mdl_mac[sa_slot]  = d.mac_sa;  // blind learn
    mdl_age[sa_slot]  = `FIB_MAX_AGE;
    mdl_port[sa_slot] = d.src_port;
    t_pkts++;
  endtask

  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `FIB_ENTRIES; i++)
        mdl_age[i] = 0;
      init_cycles = 0;
    end
    else
    begin
      // nothing may be ready or valid while the table clears
      if (init_cycles < `FIB_ENTRIES)
      begin
        if (lpp_drdy !== 1'b0 || lout_srdy !== 1'b0 || refup_srdy !== 1'b0)
        begin
          $display("ERROR at %0t: handshake high during table clear, cycle %0d", $time,
                   init_cycles);
          errors++;
          t_errs++;
        end
        init_cycles++;
      end
      if (lpp_srdy && lpp_drdy)
        predict(lpp_data);
      if (lout_srdy && lout_drdy)
      begin
        if (exp_pg.size() == 0)
        begin
          $display("lout item at %0t arrived with no descriptor outstanding", $time);
          errors++;
          t_errs++;
        end
        else
        begin
          if (lout_start !== exp_pg[0] || lout_dst_vld !== exp_mask[0])
          begin
            $display("ERROR at %0t: lout page %0h mask %b, expected page %0h mask %b", $time,
                     lout_start, lout_dst_vld, exp_pg[0], exp_mask[0]);
            errors++;
            t_errs++;
          end
          void'(exp_pg.pop_front());
          void'(exp_mask.pop_front());
        end
      end
      if (refup_srdy && refup_drdy)
      begin
        if (exp_cnt.size() == 0)
        begin
          $display("refup item at %0t arrived with no descriptor outstanding", $time);
          errors++;
          t_errs++;
        end
        else
        begin
          if (refup_page !== exp_ref_pg[0] || refup_count !== exp_cnt[0])
          begin
            $display("ERROR at %0t: refup page %0h count %0d, expected page %0h count %0d",
                     $time, refup_page, refup_count, exp_ref_pg[0], exp_cnt[0]);
            errors++;
            t_errs++;
          end
          void'(exp_ref_pg.pop_front());
          void'(exp_cnt.pop_front());
        end
      end
      if (test_end)
      begin
        $display("test %0d: %0d packets, %0d mismatches, %s", test_num, t_pkts, t_errs,
                 (t_errs == 0) ? "pass" : "FAIL");
        if (t_errs != 0)
          failed_tests++;
        t_pkts = 0;
        t_errs = 0;
      end
    end
    pending <= exp_pg.size() + exp_cnt.size();
  end

endmodule

/* verification/fib_tb_clock.sv */
module fib_tb_clock
(
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // period 8
  end

endmodule

/* verification/tb_fib_top.sv */
`include "fib_cfg.svh"

module tb_fib_top;
  import fib_pkg::*;

  localparam int total_pkts  = 72;
  localparam int cycle_limit = `FIB_ENTRIES + 40 * total_pkts;

  logic                  clk;
  logic                  reset;
  logic                  lpp_srdy;
  par_desc_t             lpp_data;
  logic                  lpp_drdy;
  logic                  lout_srdy;
  logic [`LL_PG_ASZ-1:0] lout_start;
  logic [`NUM_PORTS-1:0] lout_dst_vld;
  logic                  lout_drdy;
  logic                  refup_srdy;
  logic [`LL_PG_ASZ-1:0] refup_page;
  logic [`LL_REFSZ-1:0]  refup_count;
  logic                  refup_drdy;
  logic                  test_end;
  int                    test_num;
  int                    pending;
  int                    errors;
  int                    failed_tests;
  int                    cycles;
  int                    learned [12];  // last port of each pool MAC as a source

  fib_tb_clock clock_gen (.clk(clk));

  fib_top uut (.*);

  fib_checker scoreboard (.*);

  // pool of 12, entries 8..11 share a slot with 0..3
  function automatic logic [47:0] pool_mac(input int idx);
    logic [7:0] hi;
    hi = (idx >= 8) ? 8'h11 : 8'h00;
    return {8'h02, 24'h0, hi, 8'(idx % 8)};
  endfunction

  // group addresses in slots 8..11, clear of the pool
  function automatic logic [47:0] group_mac(input int idx);
    return {8'h01, 32'h0, 8'h80 + 8'(idx)};
  endfunction

  task automatic send_desc(input logic [47:0] da, input logic [47:0] sa, input int port);
    lpp_data.mac_da   = da;
    lpp_data.mac_sa   = sa;
    lpp_data.src_port = `PORT_SZ'(port);
    lpp_data.start_pg = `LL_PG_ASZ'($urandom);
    lpp_srdy = 1'b1;
    while (!lpp_drdy)
    begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    lpp_srdy = 1'b0;
  endtask

  task automatic send_pkt(input logic [47:0] da, input int sa_idx, input int port);
    learned[sa_idx] = port;
    send_desc(da, pool_mac(sa_idx), port);
  endtask

  task automatic finish_test(input int num);
    while (pending != 0)
    begin
      @(posedge clk);
      #1;
    end
    test_num = num;
    test_end = 1'b1;
    @(posedge clk);
    #1;
    test_end = 1'b0;
  endtask

  // output back-pressure, each ready 70 % of cycles
  always @(posedge clk)
  begin
    #1;
    lout_drdy  = ($urandom % 100) < 70;
    refup_drdy = ($urandom % 100) < 70;
  end

  always @(posedge clk)
  begin
    if (!reset)
      cycles++;
    if (cycles > cycle_limit)
    begin
      $display("timeout after %0d cycles with %0d outputs still pending", cycles, pending);
      $display("Finished with errors");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'hfbfe_b46e));
    reset      = 1'b1;
    lpp_srdy   = 1'b0;
    lpp_data   = '0;
    lout_drdy  = 1'b0;
    refup_drdy = 1'b0;
    test_end   = 1'b0;
    test_num   = 0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int i = 0; i < 4; i++)
      send_pkt(pool_mac(4 + i), i, $urandom % 4);  // unseen DAs
    finish_test(1);
    for (int i = 0; i < 4; i++)
      send_pkt(pool_mac(i), 4 + i, (learned[i] + 1 + $urandom % 3) % 4);
    finish_test(2);
    for (int i = 0; i < 4; i++)
    begin
      // put the group address in the table first
      send_desc(pool_mac(i), group_mac(i), $urandom % 4);
      send_pkt(group_mac(i), 4 + i, $urandom % 4);
      send_pkt(pool_mac(4 + i), i, (learned[4 + i] + 1) % 4);  // hits the new port
    end
    finish_test(3);
    for (int i = 0; i < 4; i++)
      send_pkt(pool_mac(4 + i), i, learned[4 + i]);
    finish_test(4);
    for (int i = 0; i < 4; i++)
    begin
      send_pkt(pool_mac(4 + i), 8 + i, $urandom % 4);  // displaces pool MAC i
      send_pkt(pool_mac(i), 4 + i, $urandom % 4);
    end
    finish_test(5);
    for (int i = 0; i < 40; i++)
    begin
      if ($urandom % 8 == 0)
        send_pkt({8'h01, 32'h0, 8'($urandom)}, $urandom % 12, $urandom % 4);
      else
        send_pkt(pool_mac($urandom % 12), $urandom % 12, $urandom % 4);
    end
    finish_test(6);

    if (pending != 0)
      $display("outputs still pending at end of run: %0d items", pending);
    $display("tests 6, failed %0d, errors %0d", failed_tests, errors);
    if (errors == 0 && pending == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule
